// File: include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// queue sizing
////////////////////////////////////////////////////////////

// entries in the instruction queue
// fetch also starts with this many credits
`define INSTR_QUEUE_DEPTH 4

// stall counter width, saturates at all ones
`define STALL_COUNT_W 16

////////////////////////////////////////////////////////////
// fixed by the instruction set
////////////////////////////////////////////////////////////

`define INSTR_W 32
`define REG_ADDR_W 5

`endif

// File: hw/mipsDecodePkg.sv
package mipsDecodePkg;

	////////////////////////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////////////////////////

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_BGEZAL  = 6'b000001,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcodeT;

	// funct field of special, bits 5:0
	typedef enum logic [5:0] {
		FN_SLLV = 6'b000100,
		FN_JR   = 6'b001000,
		FN_ADD  = 6'b100000,
		FN_SUB  = 6'b100010
	} functT;

	////////////////////////////////////////////////////////////
	// control selectors
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,
		ALU_SUB  = 3'b001,
		ALU_OR   = 3'b010,
		ALU_LUI  = 3'b011,
		ALU_SLLV = 3'b100
	} aluOpT;

	// next pc source
	typedef enum logic [1:0] {
		JUMP_ADDER = 2'b00,
		JUMP_IMM16 = 2'b01,
		JUMP_IMM26 = 2'b10,
		JUMP_RS    = 2'b11
	} jumpSelT;

	// branch compare, equality or rs >= 0
	typedef enum logic [1:0] {
		CMP_EQ  = 2'b00,
		CMP_GEZ = 2'b01
	} cmpSelT;

	// second alu operand
	typedef enum logic [1:0] {
		DATA2_RT   = 2'b00,
		DATA2_SEXT = 2'b01,
		DATA2_ZEXT = 2'b10
	} data2SelT;

	// write-back source
	typedef enum logic [1:0] {
		WDATA_ALU  = 2'b00,
		WDATA_LOAD = 2'b01,
		WDATA_LINK = 2'b10
	} wdataSelT;

	// cfg register map
	typedef enum logic {
		CFG_FWD_CTRL    = 1'b0,
		CFG_STALL_COUNT = 1'b1
	} cfgAddrT;

endpackage

// File: hw/controller.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module controller (
	input  logic [`INSTR_W-1:0]     instruction,
	input  logic                    equal,
	output logic [`REG_ADDR_W-1:0]  rs,
	output logic [`REG_ADDR_W-1:0]  rt,
	output logic [`REG_ADDR_W-1:0]  rd,
	output logic [15:0]             imm16,
	output logic [25:0]             imm26,
	output mipsDecodePkg::jumpSelT  jumpSel,
	output logic [1:0]              tUseRs,
	output logic [1:0]              tUseRt,
	output mipsDecodePkg::cmpSelT   cmpSel,
	output mipsDecodePkg::data2SelT data2Sel,
	output mipsDecodePkg::aluOpT    aluOp,
	output logic [1:0]              eTNew,
	output logic [1:0]              mTNew,
	output logic [`REG_ADDR_W-1:0]  wreg,
	output logic                    isLoad,
	output logic                    isStore,
	output mipsDecodePkg::wdataSelT wdataSel,
	output logic                    regWrite,
	output logic                    memWrite
);
	import mipsDecodePkg::*;

	// link register for jal and bgezal
	localparam logic [`REG_ADDR_W-1:0] REG_RA = `REG_ADDR_W'd31;

	opcodeT opcode;
	functT  funct;
	logic   isAdd, isSub, isOri, isLui, isLw, isSw;
	logic   isBeq, isJal, isJr, isSllv, isBgezal;

	// raw fields
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign imm16 = instruction[15:0];
	assign imm26 = instruction[25:0];
	assign opcode = opcodeT'(instruction[31:26]);
	assign funct = functT'(instruction[5:0]);

	////////////////////////////////////////////////////////////
	// instruction recognition
	////////////////////////////////////////////////////////////

	// r-type needs both opcode and funct
	assign isAdd = (opcode == OP_SPECIAL) && (funct == FN_ADD);
	assign isSub = (opcode == OP_SPECIAL) && (funct == FN_SUB);
	assign isJr = (opcode == OP_SPECIAL) && (funct == FN_JR);
	assign isSllv = (opcode == OP_SPECIAL) && (funct == FN_SLLV);
	assign isOri = (opcode == OP_ORI);
	assign isLui = (opcode == OP_LUI);
	assign isLw = (opcode == OP_LW);
	assign isSw = (opcode == OP_SW);
	assign isBeq = (opcode == OP_BEQ);
	assign isJal = (opcode == OP_JAL);
	assign isBgezal = (opcode == OP_BGEZAL);

	////////////////////////////////////////////////////////////
	// control fields
	////////////////////////////////////////////////////////////

	// branches take the 16-bit offset
	assign jumpSel = (isBeq || isBgezal) ? JUMP_IMM16 :
		isJal ? JUMP_IMM26 :
		isJr ? JUMP_RS :
		JUMP_ADDER;

	assign cmpSel = isBgezal ? CMP_GEZ : CMP_EQ;

	// lui goes through the sign-extend path, alu shifts it up
	assign data2Sel = (isLui || isLw || isSw) ? DATA2_SEXT :
		isOri ? DATA2_ZEXT :
		DATA2_RT;

	// address calc for lw/sw is an add
	assign aluOp = isSub ? ALU_SUB :
		isOri ? ALU_OR :
		isLui ? ALU_LUI :
		isSllv ? ALU_SLLV :
		ALU_ADD;

	assign wdataSel = isLw ? WDATA_LOAD :
		(isJal || isBgezal) ? WDATA_LINK :
		WDATA_ALU;

	// destination by class
	assign wreg = (isAdd || isSub || isSllv) ? rd :
		(isOri || isLui || isLw) ? rt :
		(isJal || isBgezal) ? REG_RA :
		'0;

	// bgezal links only when taken
	assign regWrite = isAdd || isSub || isOri || isLui || isLw || isJal || isSllv ||
		(isBgezal && equal);
	assign memWrite = isSw;
	assign isLoad = isLw;
	assign isStore = isSw;

	////////////////////////////////////////////////////////////
	// hazard timing
	////////////////////////////////////////////////////////////

	// tuse: 0 in decode, 1 in execute, 2 in memory, 3 unused
	assign tUseRs = (isAdd || isSub || isOri || isLw || isSw || isSllv) ? 2'd1 :
		(isBeq || isJr || isBgezal) ? 2'd0 :
		2'd3;
	// sw store data is needed only in memory
	assign tUseRt = (isAdd || isSub || isSllv) ? 2'd1 :
		isSw ? 2'd2 :
		isBeq ? 2'd0 :
		2'd3;

	// tnew seen from execute, then from memory
	assign eTNew = (isAdd || isSub || isOri || isLui || isSllv) ? 2'd1 :
		isLw ? 2'd2 :
		2'd0;
	assign mTNew = isLw ? 2'd1 : 2'd0;

endmodule

// File: hw/instrQueue.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module instrQueue (
	input  logic                clk,
	input  logic                rstN,
	input  logic                instrValid,
	input  logic [`INSTR_W-1:0] instrWord,
	input  logic                pop,
	output logic                headValid,
	output logic [`INSTR_W-1:0] headWord,
	output logic                creditReturn
);
	localparam int DEPTH = `INSTR_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	logic [`INSTR_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]    wrPtr;
	logic [PTR_W-1:0]    rdPtr;
	logic [CNT_W-1:0]    count;
	logic                doPop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	assign headValid = (count != '0);
	assign headWord = mem[rdPtr];
	// pop on an empty queue is ignored
	assign doPop = pop && headValid;

	// storage, fetch credits guarantee a free slot
	always_ff @(posedge clk) begin
		if (instrValid) begin
			mem[wrPtr] <= instrWord;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers, occupancy, credit return
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (instrValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// push and pop together leave count alone
			case ({instrValid, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit per dequeued word, a cycle later
			creditReturn <= doPop;
		end
	end

endmodule

// File: hw/hazardTracker.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module hazardTracker (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         headValid,
	input  logic                         forwardEn,
	input  logic [`REG_ADDR_W-1:0]       rs,
	input  logic [`REG_ADDR_W-1:0]       rt,
	input  logic [15:0]                  imm16,
	input  logic [1:0]                   tUseRs,
	input  logic [1:0]                   tUseRt,
	input  logic [`REG_ADDR_W-1:0]       wreg,
	input  logic                         regWrite,
	input  logic [1:0]                   eTNew,
	input  logic [1:0]                   mTNew,
	input  mipsDecodePkg::aluOpT         aluOp,
	input  mipsDecodePkg::data2SelT      data2Sel,
	input  mipsDecodePkg::wdataSelT      wdataSel,
	input  mipsDecodePkg::jumpSelT       jumpSel,
	input  mipsDecodePkg::cmpSelT        cmpSel,
	input  logic                         memWrite,
	input  logic                         isLoad,
	output logic                         pop,
	output logic                         stallPulse,
	output logic                         issueValid,
	output mipsDecodePkg::aluOpT         issueAluOp,
	output mipsDecodePkg::data2SelT      issueData2Sel,
	output mipsDecodePkg::wdataSelT      issueWdataSel,
	output mipsDecodePkg::jumpSelT       issueJumpSel,
	output mipsDecodePkg::cmpSelT        issueCmpSel,
	output logic [`REG_ADDR_W-1:0]       issueRs,
	output logic [`REG_ADDR_W-1:0]       issueRt,
	output logic [15:0]                  issueImm16,
	output logic [`REG_ADDR_W-1:0]       issueWreg,
	output logic                         issueRegWrite,
	output logic                         issueMemWrite,
	output logic                         issueIsLoad
);
	// tuse code for an operand the instruction never reads
	localparam logic [1:0] TUSE_NONE = 2'd3;

	// execute slot keeps both tnew values, memory slot only its own
	logic [`REG_ADDR_W-1:0] exWreg;
	logic                   exWe;
	logic [1:0]             exTNew;
	logic [1:0]             exMTNew;
	logic [`REG_ADDR_W-1:0] memWreg;
	logic                   memWe;
	logic [1:0]             memTNew;
	logic                   rsStall;
	logic                   rtStall;
	logic                   stall;

	// one source against one slot
	// without forwarding any pending write blocks
	function automatic logic slotHazard(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [1:0]             tUse,
		input logic [`REG_ADDR_W-1:0] dst,
		input logic                   we,
		input logic [1:0]             tNew,
		input logic                   fwd
	);
		logic used;
		used = (tUse != TUSE_NONE) && (src != '0);
		return used && we && (src == dst) && (!fwd || (tUse < tNew));
	endfunction

	////////////////////////////////////////////////////////////
	// stall decision
	////////////////////////////////////////////////////////////

	assign rsStall = slotHazard(rs, tUseRs, exWreg, exWe, exTNew, forwardEn) ||
		slotHazard(rs, tUseRs, memWreg, memWe, memTNew, forwardEn);
	assign rtStall = slotHazard(rt, tUseRt, exWreg, exWe, exTNew, forwardEn) ||
		slotHazard(rt, tUseRt, memWreg, memWe, memTNew, forwardEn);

	assign stall = headValid && (rsStall || rtStall);
	assign pop = headValid && !stall;
	// one pulse per stalled cycle
	assign stallPulse = stall;

	////////////////////////////////////////////////////////////
	// scoreboard shift and issue
	////////////////////////////////////////////////////////////

	// empty queue or stall both leave a bubble in execute
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exWe <= 1'b0;
			memWe <= 1'b0;
			issueValid <= 1'b0;
		end else begin
			exWe <= pop && regWrite;
			memWe <= exWe;
			issueValid <= pop;
		end
	end

	// payload, meaningful only under the matching enable
	always_ff @(posedge clk) begin
		memWreg <= exWreg;
		memTNew <= exMTNew;
		if (pop) begin
			exWreg <= wreg;
			exTNew <= eTNew;
			exMTNew <= mTNew;
			issueAluOp <= aluOp;
			issueData2Sel <= data2Sel;
			issueWdataSel <= wdataSel;
			issueJumpSel <= jumpSel;
			issueCmpSel <= cmpSel;
			issueRs <= rs;
			issueRt <= rt;
			issueImm16 <= imm16;
			issueWreg <= wreg;
			issueRegWrite <= regWrite;
			issueMemWrite <= memWrite;
			issueIsLoad <= isLoad;
		end
	end

endmodule

// File: hw/hazardConfig.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module hazardConfig (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      cfgWrite,
	input  mipsDecodePkg::cfgAddrT    cfgAddr,
	input  logic [`STALL_COUNT_W-1:0] cfgWData,
	output logic [`STALL_COUNT_W-1:0] cfgRData,
	input  logic                      stallPulse,
	output logic                      forwardEn
);
	import mipsDecodePkg::*;

	logic [`STALL_COUNT_W-1:0] stallCount;
	logic                      countFull;

	assign countFull = (stallCount == '1);

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// forwarding on out of reset
			forwardEn <= 1'b1;
			stallCount <= '0;
		end else begin
			if (cfgWrite && (cfgAddr == CFG_FWD_CTRL)) begin
				forwardEn <= cfgWData[0];
			end
			// any write to the counter clears it, data ignored
			if (cfgWrite && (cfgAddr == CFG_STALL_COUNT)) begin
				stallCount <= '0;
			end else if (stallPulse && !countFull) begin
				stallCount <= stallCount + 1'b1;
			end
		end
	end

	// read mux, forwarding bit sits in bit 0
	assign cfgRData = (cfgAddr == CFG_STALL_COUNT) ? stallCount :
		{{(`STALL_COUNT_W - 1){1'b0}}, forwardEn};

endmodule

// File: hw/decodeIssue.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module decodeIssue (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      instrValid,
	input  logic [`INSTR_W-1:0]       instrWord,
	output logic                      creditReturn,
	input  logic                      cmpEqual,
	input  logic                      cfgWrite,
	input  mipsDecodePkg::cfgAddrT    cfgAddr,
	input  logic [`STALL_COUNT_W-1:0] cfgWData,
	output logic [`STALL_COUNT_W-1:0] cfgRData,
	output logic                      issueValid,
	output mipsDecodePkg::aluOpT      issueAluOp,
	output mipsDecodePkg::data2SelT   issueData2Sel,
	output mipsDecodePkg::wdataSelT   issueWdataSel,
	output mipsDecodePkg::jumpSelT    issueJumpSel,
	output mipsDecodePkg::cmpSelT     issueCmpSel,
	output logic [`REG_ADDR_W-1:0]    issueRs,
	output logic [`REG_ADDR_W-1:0]    issueRt,
	output logic [15:0]               issueImm16,
	output logic [`REG_ADDR_W-1:0]    issueWreg,
	output logic                      issueRegWrite,
	output logic                      issueMemWrite,
	output logic                      issueIsLoad
);
	import mipsDecodePkg::*;

	// queue head
	logic                   headValid;
	logic [`INSTR_W-1:0]    headWord;
	logic                   pop;
	// decoded head
	logic [`REG_ADDR_W-1:0] rs, rt, wreg;
	logic [15:0]            imm16;
	logic [1:0]             tUseRs, tUseRt, eTNew, mTNew;
	logic                   isLoad, regWrite, memWrite;
	jumpSelT                jumpSel;
	cmpSelT                 cmpSel;
	data2SelT               data2Sel;
	aluOpT                  aluOp;
	wdataSelT               wdataSel;
	// tracker and config
	logic                   forwardEn;
	logic                   stallPulse;

	instrQueue instrQueue_inst (
		.clk(clk), .rstN(rstN),
		.instrValid(instrValid), .instrWord(instrWord),
		.pop(pop), .headValid(headValid), .headWord(headWord),
		.creditReturn(creditReturn)
	);

	// rd, imm26 and the store flag have no consumer in this stage
	controller controller_inst (
		.instruction(headWord), .equal(cmpEqual),
		.rs(rs), .rt(rt), .rd(), .imm16(imm16), .imm26(),
		.jumpSel(jumpSel), .tUseRs(tUseRs), .tUseRt(tUseRt),
		.cmpSel(cmpSel), .data2Sel(data2Sel), .aluOp(aluOp),
		.eTNew(eTNew), .mTNew(mTNew), .wreg(wreg),
		.isLoad(isLoad), .isStore(), .wdataSel(wdataSel),
		.regWrite(regWrite), .memWrite(memWrite)
	);

	hazardTracker hazardTracker_inst (
		.clk(clk), .rstN(rstN), .headValid(headValid), .forwardEn(forwardEn),
		.rs(rs), .rt(rt), .imm16(imm16), .tUseRs(tUseRs), .tUseRt(tUseRt),
		.wreg(wreg), .regWrite(regWrite), .eTNew(eTNew), .mTNew(mTNew),
		.aluOp(aluOp), .data2Sel(data2Sel), .wdataSel(wdataSel),
		.jumpSel(jumpSel), .cmpSel(cmpSel), .memWrite(memWrite), .isLoad(isLoad),
		.pop(pop), .stallPulse(stallPulse), .issueValid(issueValid),
		.issueAluOp(issueAluOp), .issueData2Sel(issueData2Sel),
		.issueWdataSel(issueWdataSel), .issueJumpSel(issueJumpSel),
		.issueCmpSel(issueCmpSel), .issueRs(issueRs), .issueRt(issueRt),
		.issueImm16(issueImm16), .issueWreg(issueWreg),
		.issueRegWrite(issueRegWrite), .issueMemWrite(issueMemWrite),
		.issueIsLoad(issueIsLoad)
	);

	hazardConfig hazardConfig_inst (
		.clk(clk), .rstN(rstN),
		.cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
		.cfgWData(cfgWData), .cfgRData(cfgRData),
		.stallPulse(stallPulse), .forwardEn(forwardEn)
	);

endmodule

// File: sim/issueVectors.svh
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

////////////////////////////////////////////////////////////
// decode table
////////////////////////////////////////////////////////////

// columns are row, word, cmpEqual, aluOp, data2Sel, wdataSel, jumpSel, cmpSel,
// then rs, rt, imm16, wreg, regWrite, memWrite, isLoad
localparam int NUM_ROWS = 17;

// rows 13 to 16 hold lw r2, add r3,r2,r2, ori r4,r0 and add r5,r4,r4
localparam int PAIR_FIRST = 13;
localparam int PAIR_LAST = 16;

// with forwarding on only the add after lw waits one cycle
localparam logic [`STALL_COUNT_W-1:0] FWD_STALLS = 16'd1;
// with forwarding off each consumer waits out both ex and mem slots
localparam logic [`STALL_COUNT_W-1:0] NOFWD_STALLS = 16'd4;

task automatic loadTable();
	// mixed set, pushed with random gaps
	setRow(0, 32'h00221820, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd1, 5'd2, 16'h1820, 5'd3, 1'b1, 1'b0, 1'b0);
	setRow(1, 32'h00A62022, 1'b0, ALU_SUB, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd5, 5'd6, 16'h2022, 5'd4, 1'b1, 1'b0, 1'b0);
	setRow(2, 32'h342700FF, 1'b0, ALU_OR, DATA2_ZEXT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd1, 5'd7, 16'h00FF, 5'd7, 1'b1, 1'b0, 1'b0);
	setRow(3, 32'h3C081234, 1'b0, ALU_LUI, DATA2_SEXT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd0, 5'd8, 16'h1234, 5'd8, 1'b1, 1'b0, 1'b0);
	setRow(4, 32'h8C290004, 1'b0, ALU_ADD, DATA2_SEXT, WDATA_LOAD, JUMP_ADDER, CMP_EQ,
		5'd1, 5'd9, 16'h0004, 5'd9, 1'b1, 1'b0, 1'b1);
	setRow(5, 32'hAC490008, 1'b0, ALU_ADD, DATA2_SEXT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd2, 5'd9, 16'h0008, 5'd0, 1'b0, 1'b1, 1'b0);
	setRow(6, 32'h10220010, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_IMM16, CMP_EQ,
		5'd1, 5'd2, 16'h0010, 5'd0, 1'b0, 1'b0, 1'b0);
	setRow(7, 32'h0C000100, 1'b0, ALU_ADD, DATA2_RT, WDATA_LINK, JUMP_IMM26, CMP_EQ,
		5'd0, 5'd0, 16'h0100, 5'd31, 1'b1, 1'b0, 1'b0);
	setRow(8, 32'h03E00008, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_RS, CMP_EQ,
		5'd31, 5'd0, 16'h0008, 5'd0, 1'b0, 1'b0, 1'b0);
	setRow(9, 32'h018B5004, 1'b0, ALU_SLLV, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd12, 5'd11, 16'h5004, 5'd10, 1'b1, 1'b0, 1'b0);
	// bgezal taken
	setRow(10, 32'h04310020, 1'b1, ALU_ADD, DATA2_RT, WDATA_LINK, JUMP_IMM16, CMP_GEZ,
		5'd1, 5'd17, 16'h0020, 5'd31, 1'b1, 1'b0, 1'b0);
	// unknown opcode, no writes
	setRow(11, 32'hFC000000, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd0, 5'd0, 16'h0000, 5'd0, 1'b0, 1'b0, 1'b0);
	// bgezal not taken
	setRow(12, 32'h04310020, 1'b0, ALU_ADD, DATA2_RT, WDATA_LINK, JUMP_IMM16, CMP_GEZ,
		5'd1, 5'd17, 16'h0020, 5'd31, 1'b0, 1'b0, 1'b0);
	// dependent pairs, pushed back to back
	setRow(13, 32'h8C220000, 1'b0, ALU_ADD, DATA2_SEXT, WDATA_LOAD, JUMP_ADDER, CMP_EQ,
		5'd1, 5'd2, 16'h0000, 5'd2, 1'b1, 1'b0, 1'b1);
	setRow(14, 32'h00421820, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd2, 5'd2, 16'h1820, 5'd3, 1'b1, 1'b0, 1'b0);
	setRow(15, 32'h34040005, 1'b0, ALU_OR, DATA2_ZEXT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd0, 5'd4, 16'h0005, 5'd4, 1'b1, 1'b0, 1'b0);
	setRow(16, 32'h00842820, 1'b0, ALU_ADD, DATA2_RT, WDATA_ALU, JUMP_ADDER, CMP_EQ,
		5'd4, 5'd4, 16'h2820, 5'd5, 1'b1, 1'b0, 1'b0);
endtask

`endif

// File: sim/decodeIssueTb.sv
`timescale 1ns/1ns
`include "decode_settings.svh"

module decodeIssueTb;
	import mipsDecodePkg::*;

	localparam int DEPTH = `INSTR_QUEUE_DEPTH;
	localparam int TIMEOUT_CYCLES = 60;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [`INSTR_W-1:0] instrWord;
	logic creditReturn;
	logic cmpEqual;
	logic cfgWrite;
	cfgAddrT cfgAddr;
	logic [`STALL_COUNT_W-1:0] cfgWData;
	logic [`STALL_COUNT_W-1:0] cfgRData;
	logic issueValid;
	aluOpT issueAluOp;
	data2SelT issueData2Sel;
	wdataSelT issueWdataSel;
	jumpSelT issueJumpSel;
	cmpSelT issueCmpSel;
	logic [`REG_ADDR_W-1:0] issueRs;
	logic [`REG_ADDR_W-1:0] issueRt;
	logic [15:0] issueImm16;
	logic [`REG_ADDR_W-1:0] issueWreg;
	logic issueRegWrite;
	logic issueMemWrite;
	logic issueIsLoad;

	`include "issueVectors.svh"

	// expected table
	logic [`INSTR_W-1:0] rowWord [NUM_ROWS];
	logic rowEq [NUM_ROWS];
	aluOpT rowAlu [NUM_ROWS];
	data2SelT rowData2 [NUM_ROWS];
	wdataSelT rowWdata [NUM_ROWS];
	jumpSelT rowJump [NUM_ROWS];
	cmpSelT rowCmp [NUM_ROWS];
	logic [`REG_ADDR_W-1:0] rowRs [NUM_ROWS];
	logic [`REG_ADDR_W-1:0] rowRt [NUM_ROWS];
	logic [15:0] rowImm16 [NUM_ROWS];
	logic [`REG_ADDR_W-1:0] rowWreg [NUM_ROWS];
	logic rowRegWrite [NUM_ROWS];
	logic rowMemWrite [NUM_ROWS];
	logic rowIsLoad [NUM_ROWS];

	// fetch side bookkeeping
	int credits;
	int creditPulses;
	int issuedTotal;
	int headRow;
	int seed;
	logic [`STALL_COUNT_W-1:0] readValue;

	decodeIssue decodeIssue_inst (
		.clk(clk), .rstN(rstN),
		.instrValid(instrValid), .instrWord(instrWord),
		.creditReturn(creditReturn), .cmpEqual(cmpEqual),
		.cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
		.cfgWData(cfgWData), .cfgRData(cfgRData),
		.issueValid(issueValid), .issueAluOp(issueAluOp),
		.issueData2Sel(issueData2Sel), .issueWdataSel(issueWdataSel),
		.issueJumpSel(issueJumpSel), .issueCmpSel(issueCmpSel),
		.issueRs(issueRs), .issueRt(issueRt), .issueImm16(issueImm16),
		.issueWreg(issueWreg), .issueRegWrite(issueRegWrite),
		.issueMemWrite(issueMemWrite), .issueIsLoad(issueIsLoad)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// failure reporting
	////////////////////////////////////////////////////////////

	task automatic failRun();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic valueError(input string msg);
		$display("ERR %0t: %s", $time, msg);
		failRun();
	endtask

	task automatic plainError(input string msg);
		$display("%s", msg);
		failRun();
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkAluOp(input aluOpT got, input aluOpT exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s aluOp %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic checkData2Sel(input data2SelT got, input data2SelT exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s data2Sel %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic checkWdataSel(input wdataSelT got, input wdataSelT exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s wdataSel %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic checkJumpSel(input jumpSelT got, input jumpSelT exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s jumpSel %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic checkCmpSel(input cmpSelT got, input cmpSelT exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s cmpSel %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic checkReg(input logic [`REG_ADDR_W-1:0] got,
			input logic [`REG_ADDR_W-1:0] exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s register r%0d, expected r%0d", what, got, exp));
	endtask

	task automatic checkImm(input logic [15:0] got, input logic [15:0] exp,
			input string what);
		if (got !== exp)
			valueError($sformatf("%s imm16 %h, expected %h", what, got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s flag %b, expected %b", what, got, exp));
	endtask

	task automatic checkCount(input logic [`STALL_COUNT_W-1:0] got,
			input logic [`STALL_COUNT_W-1:0] exp, input string what);
		if (got !== exp)
			valueError($sformatf("%s read %0d, expected %0d", what, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// table helpers
	////////////////////////////////////////////////////////////

	task automatic setRow(input int i, input logic [`INSTR_W-1:0] word, input logic eq,
			input aluOpT alu, input data2SelT d2, input wdataSelT wd, input jumpSelT js,
			input cmpSelT cs, input logic [`REG_ADDR_W-1:0] rs,
			input logic [`REG_ADDR_W-1:0] rt, input logic [15:0] imm,
			input logic [`REG_ADDR_W-1:0] wreg, input logic rw, input logic mw,
			input logic ld);
		rowWord[i] = word;
		rowEq[i] = eq;
		rowAlu[i] = alu;
		rowData2[i] = d2;
		rowWdata[i] = wd;
		rowJump[i] = js;
		rowCmp[i] = cs;
		rowRs[i] = rs;
		rowRt[i] = rt;
		rowImm16[i] = imm;
		rowWreg[i] = wreg;
		rowRegWrite[i] = rw;
		rowMemWrite[i] = mw;
		rowIsLoad[i] = ld;
	endtask

	// compare result only matters for bgezal
	// so the next bgezal still waiting decides what cmpEqual shows
	// two bgezal rows with different results need another row between them
	function automatic logic linkEqual(input int from);
		for (int j = from; j < NUM_ROWS; j++) begin
			if (rowWord[j][31:26] == OP_BGEZAL)
				return rowEq[j];
		end
		return 1'b0;
	endfunction

	always @(posedge clk) begin
		cmpEqual <= linkEqual(headRow);
	end

	// credit returns sampled mid-cycle
	always @(negedge clk) begin
		if (rstN && creditReturn) begin
			credits = credits + 1;
			creditPulses = creditPulses + 1;
			if (credits > DEPTH)
				plainError("fetch credits rose above the queue depth");
		end
	end

	////////////////////////////////////////////////////////////
	// fetch driver and scoreboard
	////////////////////////////////////////////////////////////

	task automatic pushRows(input int first, input int last, input bit gaps);
		int waited;
		bit pushed;
		for (int i = first; i <= last; i++) begin
			waited = 0;
			pushed = 0;
			while (!pushed) begin
				@(posedge clk);
				// random gaps skip about one edge in four
				if (credits > 0 && (!gaps || ($random(seed) & 3) != 0)) begin
					instrValid <= 1'b1;
					instrWord <= rowWord[i];
					credits = credits - 1;
					pushed = 1;
				end else begin
					instrValid <= 1'b0;
					waited++;
					if (waited > TIMEOUT_CYCLES)
						plainError($sformatf("no fetch credit came back for row %0d", i));
				end
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic expectIssues(input int first, input int last);
		int waited;
		string what;
		for (int i = first; i <= last; i++) begin
			waited = 0;
			@(negedge clk);
			while (!issueValid) begin
				waited++;
				if (waited > TIMEOUT_CYCLES)
					plainError($sformatf("row %0d was never issued", i));
				@(negedge clk);
			end
			what = $sformatf("row %0d", i);
			checkAluOp(issueAluOp, rowAlu[i], what);
			checkData2Sel(issueData2Sel, rowData2[i], what);
			checkWdataSel(issueWdataSel, rowWdata[i], what);
			checkJumpSel(issueJumpSel, rowJump[i], what);
			checkCmpSel(issueCmpSel, rowCmp[i], what);
			checkReg(issueRs, rowRs[i], {what, " rs"});
			checkReg(issueRt, rowRt[i], {what, " rt"});
			checkImm(issueImm16, rowImm16[i], what);
			checkReg(issueWreg, rowWreg[i], what);
			checkFlag(issueRegWrite, rowRegWrite[i], {what, " regWrite"});
			checkFlag(issueMemWrite, rowMemWrite[i], {what, " memWrite"});
			checkFlag(issueIsLoad, rowIsLoad[i], {what, " isLoad"});
			issuedTotal++;
			headRow = i + 1;
		end
	endtask

	// no extra issue once the rows have drained
	task automatic drainIdle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (issueValid)
				plainError("an instruction issued that was never pushed");
		end
	endtask

	task automatic runPhase(input int first, input int last, input bit gaps);
		headRow = first;
		fork
			pushRows(first, last, gaps);
			expectIssues(first, last);
		join
		drainIdle(4);
	endtask

	////////////////////////////////////////////////////////////
	// cfg port
	////////////////////////////////////////////////////////////

	task automatic writeCfg(input cfgAddrT addr, input logic [`STALL_COUNT_W-1:0] data);
		@(posedge clk);
		cfgWrite <= 1'b1;
		cfgAddr <= addr;
		cfgWData <= data;
		@(posedge clk);
		cfgWrite <= 1'b0;
	endtask

	task automatic readCfg(input cfgAddrT addr, output logic [`STALL_COUNT_W-1:0] value);
		@(posedge clk);
		cfgAddr <= addr;
		@(negedge clk);
		value = cfgRData;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		cmpEqual = 1'b0;
		cfgWrite = 1'b0;
		cfgAddr = CFG_FWD_CTRL;
		cfgWData = '0;
		credits = DEPTH;
		creditPulses = 0;
		issuedTotal = 0;
		headRow = 0;
		seed = 32'ha828_bb15;
		loadTable();

		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		repeat (2) @(posedge clk);

		// forwarding is on out of reset
		readCfg(CFG_FWD_CTRL, readValue);
		checkCount(readValue, 16'd1, "forwarding control after reset");

		// whole decode table with random fetch gaps
		runPhase(0, PAIR_FIRST - 1, 1'b1);

		// back-to-back dependent pairs, forwarding on
		writeCfg(CFG_STALL_COUNT, 16'h0000);
		runPhase(PAIR_FIRST, PAIR_LAST, 1'b0);
		readCfg(CFG_STALL_COUNT, readValue);
		checkCount(readValue, FWD_STALLS, "stall count with forwarding");

		// same pairs without forwarding
		writeCfg(CFG_FWD_CTRL, 16'h0000);
		readCfg(CFG_FWD_CTRL, readValue);
		checkCount(readValue, 16'd0, "forwarding control after write");
		// any write clears the counter whatever the data
		writeCfg(CFG_STALL_COUNT, 16'h0055);
		readCfg(CFG_STALL_COUNT, readValue);
		checkCount(readValue, 16'd0, "stall count after clear");
		runPhase(PAIR_FIRST, PAIR_LAST, 1'b0);
		readCfg(CFG_STALL_COUNT, readValue);
		checkCount(readValue, NOFWD_STALLS, "stall count without forwarding");

		// credits conserved over the whole run
		repeat (2) @(negedge clk);
		if (creditPulses == issuedTotal && credits == DEPTH) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("credit returns %0d, issues %0d, fetch credits %0d", creditPulses,
				issuedTotal, credits);
			failRun();
		end
	end

endmodule

// File: sources.f
+incdir+include
+incdir+sim
hw/mipsDecodePkg.sv
hw/controller.sv
hw/instrQueue.sv
hw/hazardTracker.sv
hw/hazardConfig.sv
hw/decodeIssue.sv
sim/decodeIssueTb.sv

// File: Makefile
# Verilator build for the decode-and-issue stage
# override any of these on the command line, e.g. make sim TOP=decodeIssueTb

VERILATOR ?= verilator
TOP       ?= decodeIssueTb
SRCS      ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(SRCS)

# the testbench ends every failure with $fatal, so the exit status is the result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(SRCS)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
